/* Bender.yml */
package:
  name: save_state

sources:
  - include_dirs:
      - .
    files:
      - svst_pkg.sv
      - svst_request_port.sv
      - save_state_sequencer.sv
      - machine_state_space.sv
      - save_state_memory.sv
      - save_state_top.sv
      - target: test
        files:
          - save_state_props.sv
          - tb_save_state.sv

/* all.f */
+incdir+.
svst_pkg.sv
svst_request_port.sv
save_state_sequencer.sv
machine_state_space.sv
save_state_memory.sv
save_state_top.sv
save_state_props.sv
tb_save_state.sv

/* machine_state_space.sv */
`default_nettype none
`timescale 1ns/1ps

`include "svst_defs.svh"

module machine_state_space (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 busy,
    input  svst_pkg::svst_addr_t state_addr,
    input  logic                 state_read_en,
    input  logic                 state_write_en,
    input  svst_pkg::svst_word_t state_write_data,
    input  svst_pkg::svst_addr_t host_addr,
    input  logic                 host_write_en,
    input  svst_pkg::svst_word_t host_write_data,
    output svst_pkg::svst_word_t state_read_data,
    output svst_pkg::svst_word_t host_read_data
);

    localparam int cpu_words  = `SAVE_STATE_CPU_LAST + 1;
    localparam int work_words = `SAVE_STATE_LAST_ADDRESS + 1 - cpu_words;
    localparam int cpu_bits   = $clog2(cpu_words);

    svst_pkg::svst_word_t cpu_bank   [cpu_words];
    svst_pkg::svst_word_t work_array [work_words];

    svst_pkg::svst_addr_t acc_addr;
    logic                 acc_read_en;
    logic                 acc_write_en;
    svst_pkg::svst_word_t acc_write_data;
    logic                 acc_in_cpu;
    svst_pkg::svst_addr_t work_index;
    svst_pkg::svst_addr_t read_addr_q;
    svst_pkg::svst_word_t cpu_q;
    svst_pkg::svst_word_t work_q;
    svst_pkg::svst_word_t read_word;

    // the sequencer owns the port while busy and host writes are lost
    assign acc_addr       = busy ? state_addr : host_addr;
    assign acc_read_en    = busy ? state_read_en : 1'b1;
    assign acc_write_en   = busy ? state_write_en : host_write_en;
    assign acc_write_data = busy ? state_write_data : host_write_data;

    assign acc_in_cpu = (acc_addr <= `SAVE_STATE_CPU_LAST);
    assign work_index = acc_addr - svst_pkg::svst_addr_t'(cpu_words);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < cpu_words; i++) begin
                cpu_bank[i] <= '0;
            end
            for (int i = 0; i < work_words; i++) begin
                work_array[i] <= '0;
            end
            read_addr_q <= '0;
            cpu_q       <= '0;
            work_q      <= '0;
        end else begin
            if (acc_read_en) begin
                read_addr_q <= acc_addr;
                if (acc_in_cpu) begin
                    cpu_q <= cpu_bank[acc_addr[cpu_bits-1:0]];
                end else begin
                    work_q <= work_array[work_index];
                end
            end
            if (acc_write_en) begin
                if (acc_in_cpu) begin
                    cpu_bank[acc_addr[cpu_bits-1:0]] <= acc_write_data;
                end else begin
                    work_array[work_index] <= acc_write_data;
                end
            end
        end
    end

    // pick the region by the address of the read one cycle back
    assign read_word = (read_addr_q <= `SAVE_STATE_CPU_LAST) ? cpu_q : work_q;

    assign state_read_data = read_word;
    assign host_read_data  = read_word;

endmodule : machine_state_space

`default_nettype wire

/* save_state_memory.sv */
`default_nettype none
`timescale 1ns/1ps

`include "svst_defs.svh"

module save_state_memory (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 mem_read_en,
    input  logic                 mem_write_en,
    input  svst_pkg::svst_addr_t mem_addr,
    input  svst_pkg::svst_word_t mem_write_data,
    output svst_pkg::svst_word_t mem_read_data
);

    svst_pkg::svst_word_t save_mem [`SAVE_STATE_LAST_ADDRESS + 1];

    // a read in the same cycle as a write wins and the write is lost
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i <= `SAVE_STATE_LAST_ADDRESS; i++) begin
                save_mem[i] <= '0;
            end
            mem_read_data <= '0;
        end else if (mem_read_en) begin
            mem_read_data <= save_mem[mem_addr];
        end else if (mem_write_en) begin
            save_mem[mem_addr] <= mem_write_data;
        end
    end

endmodule : save_state_memory

`default_nettype wire

/* save_state_props.sv */
`default_nettype none
`timescale 1ns/1ps

module save_state_props (
    input logic clock,
    input logic reset_n,
    input logic req,
    input logic ack,
    input logic busy,
    input logic mem_read_en,
    input logic mem_write_en,
    input logic state_write_en
);

    int failure_count = 0;

    // the host holds req until ack has been seen
    ack_needs_req: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(ack) |-> req)
        else begin
            $error("ack rose while req was low");
            failure_count++;
        end

    mem_port_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
        !(mem_read_en && mem_write_en))
        else begin
            $error("save memory read and write enabled together");
            failure_count++;
        end

    state_write_only_busy: assert property (@(posedge clock) disable iff (!reset_n)
        state_write_en |-> busy)
        else begin
            $error("sequencer wrote the state space while idle");
            failure_count++;
        end

    // 32 words plus the pipeline fit well inside this window
    busy_ends: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(busy) |-> ##[1:48] !busy)
        else begin
            $error("busy stayed high after a start");
            failure_count++;
        end

endmodule : save_state_props

bind save_state_top save_state_props save_state_props_inst (
    .clock          (clock),
    .reset_n        (reset_n),
    .req            (req),
    .ack            (ack),
    .busy           (busy),
    .mem_read_en    (mem_read_en),
    .mem_write_en   (mem_write_en),
    .state_write_en (state_write_en)
);

`default_nettype wire

/* save_state_sequencer.sv */
`default_nettype none
`timescale 1ns/1ps

`include "svst_defs.svh"

module save_state_sequencer (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 begin_save,
    input  logic                 begin_load,
    input  svst_pkg::svst_word_t state_read_data,
    input  svst_pkg::svst_word_t mem_read_data,
    output logic                 stall,
    output logic                 state_read_en,
    output logic                 state_write_en,
    output svst_pkg::svst_addr_t state_addr,
    output svst_pkg::svst_word_t state_write_data,
    output logic                 mem_read_en,
    output logic                 mem_write_en,
    output svst_pkg::svst_addr_t mem_addr,
    output svst_pkg::svst_word_t mem_write_data
);

    localparam svst_pkg::svst_addr_t last_addr = `SAVE_STATE_LAST_ADDRESS;

    typedef enum logic [1:0] {IDLE, SAVING, LOADING} seq_state_t;

    seq_state_t           state;
    logic                 saving;
    logic                 src_en;
    svst_pkg::svst_addr_t src_addr;
    logic                 pipe_valid;
    svst_pkg::svst_addr_t pipe_addr;
    logic                 dst_en;
    svst_pkg::svst_addr_t dst_addr;

    // source side is read at src_addr, destination written two cycles later
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state      <= IDLE;
            src_en     <= 1'b0;
            src_addr   <= '0;
            pipe_valid <= 1'b0;
            pipe_addr  <= '0;
            dst_en     <= 1'b0;
            dst_addr   <= '0;
        end else begin
            pipe_valid <= src_en;
            pipe_addr  <= src_addr;
            dst_en     <= pipe_valid;
            dst_addr   <= pipe_addr;
            case (state)
                IDLE: begin
                    if (begin_save) begin
                        state    <= SAVING;
                        src_en   <= 1'b1;
                        src_addr <= '0;
                    end else if (begin_load) begin
                        state    <= LOADING;
                        src_en   <= 1'b1;
                        src_addr <= '0;
                    end
                end
                default: begin
                    if (src_en) begin
                        if (src_addr == last_addr) begin
                            src_en <= 1'b0;
                        end else begin
                            src_addr <= src_addr + svst_pkg::svst_addr_t'(1);
                        end
                    end
                    // done once the last word has gone out on the write side
                    if (dst_en && dst_addr == last_addr) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // read data arrives one cycle after the read and is written the cycle after that
    always_ff @(posedge clock) begin
        state_write_data <= mem_read_data;
        mem_write_data   <= state_read_data;
    end

    assign saving = (state == SAVING);

    // the start pulse already counts as busy
    assign stall = (state != IDLE) || begin_save || begin_load;

    assign state_read_en  = saving && src_en;
    assign mem_write_en   = saving && dst_en;
    assign mem_read_en    = (state == LOADING) && src_en;
    assign state_write_en = (state == LOADING) && dst_en;

    assign state_addr = saving ? src_addr : dst_addr;
    assign mem_addr   = saving ? dst_addr : src_addr;

endmodule : save_state_sequencer

`default_nettype wire

/* save_state_testdata.txt */
# command address data: W write, R read and expect, S save, L load
# address and data are hex, save and load ignore both
R 00 0000
R 1f 0000
W 03 1234
W 14 abcd
R 14 abcd
L 00 0000
R 03 0000
R 14 0000
W 00 a5a5
W 07 0707
W 08 8888
W 1f f00f
R 07 0707
R 08 8888
S 00 0000
W 00 1111
W 07 2222
W 08 3333
W 1f 4444
L 00 0000
R 00 a5a5
R 07 0707
R 08 8888
R 1f f00f
W 08 5555
S 00 0000
W 08 6666
L 00 0000
R 08 5555
R 00 a5a5

/* save_state_top.sv */
`default_nettype none
`timescale 1ns/1ps

module save_state_top (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 req,
    input  svst_pkg::svst_op_t   op,
    input  svst_pkg::svst_addr_t host_addr,
    input  logic                 host_write_en,
    input  svst_pkg::svst_word_t host_write_data,
    output logic                 ack,
    output logic                 busy,
    output svst_pkg::svst_word_t host_read_data
);

    logic                 begin_save;
    logic                 begin_load;
    logic                 state_read_en;
    logic                 state_write_en;
    svst_pkg::svst_addr_t state_addr;
    svst_pkg::svst_word_t state_write_data;
    svst_pkg::svst_word_t state_read_data;
    logic                 mem_read_en;
    logic                 mem_write_en;
    svst_pkg::svst_addr_t mem_addr;
    svst_pkg::svst_word_t mem_write_data;
    svst_pkg::svst_word_t mem_read_data;

    svst_request_port svst_request_port_inst (
        .clock      (clock),
        .reset_n    (reset_n),
        .req        (req),
        .op         (op),
        .busy       (busy),
        .ack        (ack),
        .begin_save (begin_save),
        .begin_load (begin_load)
    );

    save_state_sequencer save_state_sequencer_inst (
        .clock            (clock),
        .reset_n          (reset_n),
        .begin_save       (begin_save),
        .begin_load       (begin_load),
        .state_read_data  (state_read_data),
        .mem_read_data    (mem_read_data),
        .stall            (busy),
        .state_read_en    (state_read_en),
        .state_write_en   (state_write_en),
        .state_addr       (state_addr),
        .state_write_data (state_write_data),
        .mem_read_en      (mem_read_en),
        .mem_write_en     (mem_write_en),
        .mem_addr         (mem_addr),
        .mem_write_data   (mem_write_data)
    );

    machine_state_space machine_state_space_inst (
        .clock            (clock),
        .reset_n          (reset_n),
        .busy             (busy),
        .state_addr       (state_addr),
        .state_read_en    (state_read_en),
        .state_write_en   (state_write_en),
        .state_write_data (state_write_data),
        .host_addr        (host_addr),
        .host_write_en    (host_write_en),
        .host_write_data  (host_write_data),
        .state_read_data  (state_read_data),
        .host_read_data   (host_read_data)
    );

    save_state_memory save_state_memory_inst (
        .clock          (clock),
        .reset_n        (reset_n),
        .mem_read_en    (mem_read_en),
        .mem_write_en   (mem_write_en),
        .mem_addr       (mem_addr),
        .mem_write_data (mem_write_data),
        .mem_read_data  (mem_read_data)
    );

endmodule : save_state_top

`default_nettype wire

/* svst_defs.svh */
`ifndef SVST_DEFS_SVH
`define SVST_DEFS_SVH

// width of an address into the state space or the save memory
`define SAVE_STATE_BITS 5

// last word of the state space, also the last word of the save memory
`define SAVE_STATE_LAST_ADDRESS 31

// the CPU register bank ends here and working state starts one word above
`define SAVE_STATE_CPU_LAST 7

`endif

/* svst_pkg.sv */
`default_nettype none

`include "svst_defs.svh"

package svst_pkg;

    typedef logic [15:0] svst_word_t;

    typedef logic [`SAVE_STATE_BITS-1:0] svst_addr_t;

    // operation carried by op while req is high
    typedef enum logic {
        OP_SAVE = 1'b0,
        OP_LOAD = 1'b1
    } svst_op_t;

endpackage : svst_pkg

`default_nettype wire

/* svst_request_port.sv */
`default_nettype none
`timescale 1ns/1ps

module svst_request_port (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               req,
    input  svst_pkg::svst_op_t op,
    input  logic               busy,
    output logic               ack,
    output logic               begin_save,
    output logic               begin_load
);

    typedef enum logic [1:0] {IDLE, RUNNING, ACKED} port_state_t;

    port_state_t state;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state      <= IDLE;
            ack        <= 1'b0;
            begin_save <= 1'b0;
            begin_load <= 1'b0;
        end else begin
            begin_save <= 1'b0;
            begin_load <= 1'b0;
            case (state)
                IDLE: begin
                    if (req && !busy && !ack) begin
                        begin_save <= (op == svst_pkg::OP_SAVE);
                        begin_load <= (op == svst_pkg::OP_LOAD);
                        state      <= RUNNING;
                    end
                end
                RUNNING: begin
                    // the start pulse keeps busy high in the first running cycle
                    if (!busy) begin
                        ack   <= 1'b1;
                        state <= ACKED;
                    end
                end
                ACKED: begin
                    // hold ack until the host lets go of req
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule : svst_request_port

`default_nettype wire

/* tb_save_state.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_save_state;

    localparam int wait_limit = 100;

    logic                 clock;
    logic                 reset_n;
    logic                 req;
    svst_pkg::svst_op_t   op;
    svst_pkg::svst_addr_t host_addr;
    logic                 host_write_en;
    svst_pkg::svst_word_t host_write_data;
    logic                 ack;
    logic                 busy;
    svst_pkg::svst_word_t host_read_data;

    int         mismatch_count;
    int         other_error_count;
    logic [7:0] lfsr_state;

    save_state_top save_state_top_inst (
        .clock           (clock),
        .reset_n         (reset_n),
        .req             (req),
        .op              (op),
        .host_addr       (host_addr),
        .host_write_en   (host_write_en),
        .host_write_data (host_write_data),
        .ack             (ack),
        .busy            (busy),
        .host_read_data  (host_read_data)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // 8-bit Fibonacci LFSR with taps 8, 6, 5 and 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] value);
        return {value[6:0], value[7] ^ value[5] ^ value[4] ^ value[3]};
    endfunction

    task automatic random_bits(input int count, output int value);
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | lfsr_state[0];
        end
    endtask

    task automatic check_word(input string name, input svst_pkg::svst_word_t expected,
                              input svst_pkg::svst_word_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic host_write(input svst_pkg::svst_addr_t addr,
                              input svst_pkg::svst_word_t data);
        @(posedge clock);
        host_addr       <= addr;
        host_write_en   <= 1'b1;
        host_write_data <= data;
        @(posedge clock);
        host_write_en <= 1'b0;
    endtask

    // read data is registered one cycle after the address
    task automatic host_read(input svst_pkg::svst_addr_t addr,
                             output svst_pkg::svst_word_t data);
        @(posedge clock);
        host_addr <= addr;
        @(posedge clock);
        @(negedge clock);
        data = host_read_data;
    endtask

    task automatic run_request(input string name, input svst_pkg::svst_op_t kind);
        int   cycles;
        int   hold;
        logic saw_busy;
        saw_busy = 1'b0;
        cycles   = 0;
        @(posedge clock);
        req <= 1'b1;
        op  <= kind;
        while (ack !== 1'b1 && cycles < wait_limit) begin
            @(negedge clock);
            saw_busy = saw_busy | busy;
            cycles++;
        end
        if (ack !== 1'b1) begin
            $display("%s: ack did not rise within %0d cycles", name, wait_limit);
            other_error_count++;
        end else begin
            check_flag({name, " busy before ack"}, 1'b1, saw_busy);
            check_flag({name, " busy at ack"}, 1'b0, busy);
        end
        // ack must hold and no second run may start while req stays high
        random_bits(3, hold);
        repeat (hold) begin
            @(negedge clock);
            check_flag({name, " ack held"}, 1'b1, ack);
            check_flag({name, " no restart"}, 1'b0, busy);
        end
        @(posedge clock);
        req    <= 1'b0;
        cycles = 0;
        while (ack !== 1'b0 && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (ack !== 1'b0) begin
            $display("%s: ack did not fall within %0d cycles", name, wait_limit);
            other_error_count++;
        end
    endtask

    initial begin
        int                   fd;
        int                   line_no;
        int                   fields;
        int                   idle;
        int                   assertion_failures;
        int unsigned          addr_val;
        int unsigned          data_val;
        byte                  cmd;
        string                line;
        string                name;
        svst_pkg::svst_word_t word;

        mismatch_count    = 0;
        other_error_count = 0;
        lfsr_state        = 8'd60;
        line_no           = 0;
        reset_n         <= 1'b0;
        req             <= 1'b0;
        op              <= svst_pkg::OP_SAVE;
        host_addr       <= '0;
        host_write_en   <= 1'b0;
        host_write_data <= '0;
        repeat (10) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        check_flag("reset ack", 1'b0, ack);
        check_flag("reset busy", 1'b0, busy);

        fd = $fopen("save_state_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open save_state_testdata.txt");
            other_error_count++;
        end else begin
            while ($fgets(line, fd)) begin
                line_no++;
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%c %h %h", cmd, addr_val, data_val);
                name   = $sformatf("line %0d", line_no);
                if (fields != 3) begin
                    $display("%s of the data file could not be parsed", name);
                    other_error_count++;
                    continue;
                end
                case (cmd)
                    "W": host_write(svst_pkg::svst_addr_t'(addr_val),
                                    svst_pkg::svst_word_t'(data_val));
                    "R": begin
                        host_read(svst_pkg::svst_addr_t'(addr_val), word);
                        check_word({name, " read"}, svst_pkg::svst_word_t'(data_val), word);
                    end
                    "S": run_request({name, " save"}, svst_pkg::OP_SAVE);
                    "L": run_request({name, " load"}, svst_pkg::OP_LOAD);
                    default: begin
                        $display("%s holds an unknown command", name);
                        other_error_count++;
                    end
                endcase
                random_bits(3, idle);
                repeat (idle) @(posedge clock);
            end
            $fclose(fd);
        end

        assertion_failures = save_state_top_inst.save_state_props_inst.failure_count;
        $display("mismatches: %0d, other errors: %0d, assertion failures: %0d",
                 mismatch_count, other_error_count, assertion_failures);
        if (mismatch_count == 0 && other_error_count == 0 && assertion_failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_save_state

`default_nettype wire
